//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_arcade_controls
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the testbench prints its pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
hw/ctrl_pkg.sv
hw/spin_pkg.sv
hw/key_decoder.sv
hw/quad_stepper.sv
hw/spinner_emulator.sv
hw/encoder_halver.sv
hw/dip_loader.sv
hw/arcade_controls.sv
test/arcade_controls_sva.sv
test/tb_arcade_controls.sv

//--- hw/arcade_controls.sv
/* Player-control front end; outputs are active low toward the game core.
   Real encoder on user_in[1:0] takes over on its first movement. */
`timescale 1ns/1ns
`default_nettype none

module arcade_controls (
	input  wire                CLK_48M,
	input  wire                rst_n,
	input  wire [10:0]         ps2_key,
	input  wire [24:0]         ps2_mouse,
	input  wire [31:0]         joy,            // Both pads ORed
	input  wire [7:0]          user_in,        // AB encoder on [1:0] and fire on [3]
	input  wire                io_spinner_en,
	input  ctrl_pkg::dl_wr_t   dl,
	output ctrl_pkg::game_in_t game_in,
	output spin_pkg::quad_t    spinner,
	output logic [7:0]         dip_sw
);

	ctrl_pkg::btn_t  btns;
	spin_pkg::quad_t emu_ab;
	spin_pkg::quad_t io_ab;
	logic            mouse_seen;
	logic            use_io;   // Real encoder selected
	logic [1:0]      enc_q;    // Encoder change detect
	logic            io_fire;

	key_decoder key_decoder_inst (
		.CLK_48M (CLK_48M),
		.rst_n   (rst_n),
		.ps2_key (ps2_key),
		.btns    (btns)
	);

	spinner_emulator spinner_emulator_inst (
		.CLK_48M    (CLK_48M),
		.rst_n      (rst_n),
		.ps2_mouse  (ps2_mouse),
		.ab         (emu_ab),
		.mouse_seen (mouse_seen)
	);

	encoder_halver encoder_halver_inst (
		.CLK_48M (CLK_48M),
		.rst_n   (rst_n),
		.enc     (user_in[1:0]),
		.ab      (io_ab)
	);

	dip_loader dip_loader_inst (
		.CLK_48M (CLK_48M),
		.rst_n   (rst_n),
		.dl      (dl),
		.dip_sw  (dip_sw)
	);

	////////////////////////////////////////////////////////////////////////////
	// Spinner source select

	always_ff @(posedge CLK_48M) begin
		if (!rst_n) begin
			enc_q  <= user_in[1:0];  // Idle encoder level is not movement
			use_io <= 1'b0;
		end else begin
			enc_q <= user_in[1:0];
			if (mouse_seen || !io_spinner_en)
				use_io <= 1'b0;  // Mouse or disable wins
			else if (enc_q != user_in[1:0])
				use_io <= 1'b1;
		end
	end

	assign spinner = use_io ? io_ab : emu_ab;

	////////////////////////////////////////////////////////////////////////////
	// Button merge, inverted for the game

	assign io_fire = use_io & ~user_in[3];  // Low-active cabinet fire button

	assign game_in.shot    = ~(btns.fire | joy[4] | (|ps2_mouse[1:0]) | io_fire);
	assign game_in.start1  = ~(btns.start1 | joy[6]);
	assign game_in.start2  = ~(btns.start2 | joy[8]);
	assign game_in.coin1   = ~(btns.coin1 | joy[7]);
	assign game_in.coin2   = ~btns.coin2;    // Keyboard only
	assign game_in.service = ~btns.service;

endmodule

`default_nettype wire

//--- hw/ctrl_pkg.sv
/* Cabinet control types and PS/2 set-2 key codes.
   Extended keys (arrows) match on the low code byte only. */
`default_nettype none

package ctrl_pkg;

	// Active-high held button levels
	typedef struct packed {
		logic left;
		logic right;
		logic fire;
		logic fast;
		logic coin1;
		logic coin2;
		logic start1;
		logic start2;
		logic pause;
		logic service;
	} btn_t;

	// Active-low game side inputs
	typedef struct packed {
		logic shot;
		logic service;
		logic start1;
		logic start2;
		logic coin1;
		logic coin2;
	} game_in_t;

	// One download write from the loader
	typedef struct packed {
		logic        wr;     // Write strobe
		logic [7:0]  index;  // Download target
		logic [24:0] addr;
		logic [7:0]  data;
	} dl_wr_t;

	localparam logic [7:0] KEY_START1  = 8'h16;  // 1
	localparam logic [7:0] KEY_START2  = 8'h1E;  // 2
	localparam logic [7:0] KEY_COIN1   = 8'h2E;  // 5
	localparam logic [7:0] KEY_COIN2   = 8'h36;  // 6
	localparam logic [7:0] KEY_SERVICE = 8'h46;  // 9
	localparam logic [7:0] KEY_PAUSE   = 8'h4D;  // P
	localparam logic [7:0] KEY_FAST    = 8'h11;  // Alt
	localparam logic [7:0] KEY_LEFT    = 8'h6B;
	localparam logic [7:0] KEY_RIGHT   = 8'h74;
	localparam logic [7:0] KEY_FIRE    = 8'h29;  // Space

	localparam logic [7:0] DIP_INDEX = 8'd254;
	localparam int         DIP_BYTES = 8;
	localparam int         DIP_AW    = $clog2(DIP_BYTES);  // Byte select width

endpackage

`default_nettype wire

//--- hw/dip_loader.sv
/* DIP bank loaded from download index 254; only byte 0 reaches the game.
   Bank reads back as all switches off until loaded. */
`timescale 1ns/1ns
`default_nettype none

module dip_loader (
	input  wire              CLK_48M,
	input  wire              rst_n,
	input  ctrl_pkg::dl_wr_t dl,
	output logic [7:0]       dip_sw  // Active low
);

	logic [7:0] bank [ctrl_pkg::DIP_BYTES];
	logic       hit;

	// Right index and inside the bank
	assign hit = dl.wr && (dl.index == ctrl_pkg::DIP_INDEX) &&
	             (dl.addr < 25'(ctrl_pkg::DIP_BYTES));

	always_ff @(posedge CLK_48M) begin
		if (!rst_n) begin
			for (int i = 0; i < ctrl_pkg::DIP_BYTES; i++)
				bank[i] <= '0;
		end else if (hit) begin
			bank[dl.addr[ctrl_pkg::DIP_AW-1:0]] <= dl.data;
		end
	end

	assign dip_sw = ~bank[0];  // Stored ones mean switch on

endmodule

`default_nettype wire

//--- hw/encoder_halver.sv
/* 600-pulse AB encoder in, game-rate pattern out; only phase A edges count.
   Phase changes faster than 12 MHz are lost. */
`timescale 1ns/1ns
`default_nettype none

module encoder_halver (
	input  wire             CLK_48M,
	input  wire             rst_n,
	input  wire [1:0]       enc,  // {B, A}
	output spin_pkg::quad_t ab
);

	logic [spin_pkg::IO_CE_W-1:0] ce_cnt;  // 12 MHz sample divider
	logic                         a_q;     // Sampled phase A
	logic                         tick;
	logic                         step;

	assign tick = (ce_cnt == '0);
	assign step = tick & (a_q != enc[0]);  // One step per A change

	always_ff @(posedge CLK_48M) begin
		if (!rst_n) begin
			ce_cnt <= '0;
			a_q    <= enc[0];
		end else begin
			ce_cnt <= (ce_cnt == spin_pkg::IO_CE_LAST) ? '0 : ce_cnt + 1'b1;
			if (tick)
				a_q <= enc[0];
		end
	end

	// A xor B gives rotation sense
	quad_stepper quad_stepper_inst (
		.CLK_48M (CLK_48M),
		.rst_n   (rst_n),
		.step    (step),
		.up      (enc[0] ^ enc[1]),
		.ab      (ab)
	);

endmodule

`default_nettype wire

//--- hw/key_decoder.sv
/* Key events arrive as a toggle in bit 10; a missed toggle loses the event.
   Codes outside the cabinet map leave the buttons untouched. */
`timescale 1ns/1ns
`default_nettype none

module key_decoder (
	input  wire               CLK_48M,
	input  wire               rst_n,
	input  wire [10:0]        ps2_key,  // {toggle, pressed, unused, code}
	output ctrl_pkg::btn_t    btns
);

	logic       tog_q;    // Last seen event toggle
	logic       pressed;
	logic [7:0] code;

	assign pressed = ps2_key[9];
	assign code    = ps2_key[7:0];

	always_ff @(posedge CLK_48M) begin
		if (!rst_n) begin
			tog_q <= ps2_key[10];  // Track input so reset creates no event
			btns  <= '0;
		end else begin
			tog_q <= ps2_key[10];
			if (tog_q != ps2_key[10]) begin  // New key event
				case (code)
					ctrl_pkg::KEY_START1:  btns.start1  <= pressed;
					ctrl_pkg::KEY_START2:  btns.start2  <= pressed;
					ctrl_pkg::KEY_COIN1:   btns.coin1   <= pressed;
					ctrl_pkg::KEY_COIN2:   btns.coin2   <= pressed;
					ctrl_pkg::KEY_SERVICE: btns.service <= pressed;
					ctrl_pkg::KEY_PAUSE:   btns.pause   <= pressed;
					// Play keys
					ctrl_pkg::KEY_FAST:    btns.fast    <= pressed;
					ctrl_pkg::KEY_LEFT:    btns.left    <= pressed;
					ctrl_pkg::KEY_RIGHT:   btns.right   <= pressed;
					ctrl_pkg::KEY_FIRE:    btns.fire    <= pressed;
					default: ;  // Unmapped key
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/quad_stepper.sv
/* One position per step strobe; the strobe must be a single-cycle pulse. */
`timescale 1ns/1ns
`default_nettype none

module quad_stepper (
	input  wire             CLK_48M,
	input  wire             rst_n,
	input  wire             step,  // Advance one position
	input  wire             up,    // 1 = 00,01,11,10 order
	output spin_pkg::quad_t ab
);

	always_ff @(posedge CLK_48M) begin
		if (!rst_n) begin
			ab <= spin_pkg::QUAD_IDLE;
		end else if (step) begin
			case ({up, ab})
				// Up walk
				3'b1_00: ab <= 2'b01;
				3'b1_01: ab <= 2'b11;
				3'b1_11: ab <= 2'b10;
				3'b1_10: ab <= 2'b00;
				// Down walk
				3'b0_00: ab <= 2'b10;
				3'b0_10: ab <= 2'b11;
				3'b0_11: ab <= 2'b01;
				default: ab <= 2'b00;  // 01 going down
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/spin_pkg.sv
/* Spinner timing for a 48 MHz system clock and the AB pattern type.
   Divider lengths are counted in CLK_48M cycles, step period in 6 MHz ticks. */
`default_nettype none

package spin_pkg;

	typedef logic [1:0] quad_t;  // {A, B}

	localparam quad_t QUAD_IDLE = 2'b11;

	localparam int POS_W = 12;  // Two's complement signed position

	// Emulator tick of 48 / 8 = 6 MHz
	localparam int                   EMU_CE_DIV  = 8;
	localparam int                   EMU_CE_W    = $clog2(EMU_CE_DIV);
	localparam logic [EMU_CE_W-1:0]  EMU_CE_LAST = EMU_CE_W'(EMU_CE_DIV - 1);

	// One emitted step per 1500 ticks for 4 kHz
	localparam int                   STEP_TICKS  = 1500;
	localparam int                   STEP_W      = $clog2(STEP_TICKS);
	localparam logic [STEP_W-1:0]    STEP_LAST   = STEP_W'(STEP_TICKS - 1);

	// Real encoder sampling at 48 / 4 = 12 MHz
	localparam int                   IO_CE_DIV   = 4;
	localparam int                   IO_CE_W     = $clog2(IO_CE_DIV);
	localparam logic [IO_CE_W-1:0]   IO_CE_LAST  = IO_CE_W'(IO_CE_DIV - 1);

endpackage

`default_nettype wire

//--- hw/spinner_emulator.sv
/* Mouse dx feeds a signed position drained toward zero at 4 kHz.
   Reports are dropped while the position is near saturation. */
`timescale 1ns/1ns
`default_nettype none

module spinner_emulator (
	input  wire             CLK_48M,
	input  wire             rst_n,
	input  wire [24:0]      ps2_mouse,  // {toggle, .., dx, .., dx sign, .., buttons}
	output spin_pkg::quad_t ab,
	output logic            mouse_seen  // One tick wide per report
);

	logic [spin_pkg::EMU_CE_W-1:0] ce_cnt;    // 6 MHz divider
	logic [spin_pkg::STEP_W-1:0]   step_cnt;  // Step period counter
	logic [spin_pkg::POS_W-1:0]    pos;       // Signed pending steps
	logic                          tog_q;
	logic                          tick;
	logic                          add_ok;
	logic                          step;
	logic [spin_pkg::POS_W-1:0]    dx;
	logic [spin_pkg::POS_W-1:0]    step_adj;
	logic [spin_pkg::POS_W-1:0]    add_val;

	assign tick       = (ce_cnt == '0);
	assign mouse_seen = tick & (tog_q != ps2_mouse[24]);

	// Top two bits equal means room for one more 8-bit report
	assign add_ok = (pos[spin_pkg::POS_W-1] == pos[spin_pkg::POS_W-2]);

	assign dx = {{(spin_pkg::POS_W-8){ps2_mouse[4]}}, ps2_mouse[15:8]};

	assign step = tick & (step_cnt == '0) & (pos != '0);

	// Negative walks up toward zero and positive walks down
	assign step_adj = pos[spin_pkg::POS_W-1] ? spin_pkg::POS_W'(1) : '1;
	assign add_val  = (mouse_seen && add_ok) ? dx : '0;

	always_ff @(posedge CLK_48M) begin
		if (!rst_n) begin
			ce_cnt   <= '0;
			step_cnt <= '0;
			pos      <= '0;
			tog_q    <= ps2_mouse[24];  // No report out of reset
		end else begin
			ce_cnt <= (ce_cnt == spin_pkg::EMU_CE_LAST) ? '0 : ce_cnt + 1'b1;
			if (tick) begin
				tog_q    <= ps2_mouse[24];
				step_cnt <= (step_cnt == spin_pkg::STEP_LAST) ? '0 : step_cnt + 1'b1;
				// Drain and new report combine in one update
				pos      <= pos + (step ? step_adj : '0) + add_val;
			end
		end
	end

	quad_stepper quad_stepper_inst (
		.CLK_48M (CLK_48M),
		.rst_n   (rst_n),
		.step    (step),
		.up      (pos[spin_pkg::POS_W-1]),
		.ab      (ab)
	);

endmodule

`default_nettype wire

//--- test/arcade_controls_sva.sv
/* Bound into arcade_controls; sees the source select so a path switch
   is not taken for a spinner step. */
`timescale 1ns/1ns
`default_nettype none

module arcade_controls_sva (
	input wire                CLK_48M,
	input wire                rst_n,
	input wire                use_io,
	input wire [1:0]          spinner,
	input ctrl_pkg::game_in_t game_in,
	input wire [7:0]          dip_sw
);

	// Quadrature steps flip one bit while the source holds
	a_one_bit_step: assert property (@(posedge CLK_48M) disable iff (!rst_n)
		($past(rst_n) && (use_io == $past(use_io)) && (spinner != $past(spinner)))
		|-> $onehot(spinner ^ $past(spinner)))
		else $error("spinner changed more than one bit in a step");

	// Idle outputs right after reset release
	a_reset_values: assert property (@(posedge CLK_48M)
		$rose(rst_n) |-> (game_in == 6'h3f && spinner == 2'b11 && dip_sw == 8'hff))
		else $error("outputs left their reset values after reset");

endmodule

bind arcade_controls arcade_controls_sva arcade_controls_sva_inst (
	.CLK_48M (CLK_48M),
	.rst_n   (rst_n),
	.use_io  (use_io),
	.spinner (spinner),
	.game_in (game_in),
	.dip_sw  (dip_sw)
);

`default_nettype wire

//--- test/controls_trace.txt
# name kind a b c exp, values in hex
# rst: a=game_in b=spinner c=dip_sw | key: a=code b=pressed | joy: a=joy b=mouse buttons
# dip: a=index b=addr c=data | mouse: a=|dx| (0 random) b=negative | enc: a=A changes
reset_state     rst   3f 3 ff 0
fire_press      key   29 1 0 1f
fire_release    key   29 0 0 3f
start1_press    key   16 1 0 37
start2_press    key   1e 1 0 33
coin1_press     key   2e 1 0 31
coin2_press     key   36 1 0 30
service_press   key   46 1 0 20
pause_press     key   4d 1 0 20
start2_release  key   1e 0 0 24
coin1_release   key   2e 0 0 26
coin2_release   key   36 0 0 27
service_release key   46 0 0 37
joy_shot_key    joy   10 0 0 17
joy_start1_key  joy   40 0 0 37
joy_clear_key   joy   0 0 0 37
start1_release  key   16 0 0 3f
joy_coin1       joy   80 0 0 3d
joy_start2      joy   100 0 0 3b
mouse_btn_left  joy   0 1 0 1f
mouse_btn_right joy   0 2 0 1f
joy_clear       joy   0 0 0 3f
dip_load        dip   fe 0 a5 5a
dip_bad_index   dip   fd 0 00 5a
dip_bad_addr    dip   fe 8 ff 5a
dip_byte1       dip   fe 1 33 5a
dip_reload      dip   fe 0 0f f0
mouse_pos5      mouse 5 0 0 0
mouse_neg3      mouse 3 1 0 0
mouse_rand_pos  mouse 0 0 0 0
mouse_rand_neg  mouse 0 1 0 0
encoder_real    enc   6 0 0 1f

//--- test/tb_arcade_controls.sv
/* Trace driven; run from the project root so the trace path resolves.
   Mouse rows take several ms of sim time each at the 4 kHz step rate. */
`timescale 1ns/1ns
`default_nettype none

module tb_arcade_controls;

	localparam int STEP_CYC = spin_pkg::STEP_TICKS * spin_pkg::EMU_CE_DIV;  // Cycles per step

	logic               CLK_48M = 1'b0;
	logic               rst_n;
	logic [10:0]        ps2_key;
	logic [24:0]        ps2_mouse;
	logic [31:0]        joy;
	logic [7:0]         user_in;
	logic               io_spinner_en;
	ctrl_pkg::dl_wr_t   dl;
	ctrl_pkg::game_in_t game_in;
	logic [1:0]         spinner;
	logic [7:0]         dip_sw;

	string       t_name[$];
	string       t_kind[$];
	logic [31:0] t_a[$];
	logic [31:0] t_b[$];
	logic [31:0] t_c[$];
	logic [31:0] t_exp[$];
	logic [31:0] lfsr = 32'hfccf;
	logic        key_tog = 1'b0;
	logic        mouse_tog = 1'b0;
	logic [1:0]  mouse_btn = 2'b00;
	logic [1:0]  emu_pat = 2'b11;  // Expected emulator pattern
	int          errors = 0;
	int          budget = 0;
	bit          loaded = 0;

	always #20 CLK_48M = ~CLK_48M;  // 25 MHz stand-in with a 40 ns period

	arcade_controls arcade_controls_inst (
		.CLK_48M       (CLK_48M),
		.rst_n         (rst_n),
		.ps2_key       (ps2_key),
		.ps2_mouse     (ps2_mouse),
		.joy           (joy),
		.user_in       (user_in),
		.io_spinner_en (io_spinner_en),
		.dl            (dl),
		.game_in       (game_in),
		.spinner       (spinner),
		.dip_sw        (dip_sw)
	);

	////////////////////////////////////////////////////////////////////////////
	// Helpers

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("Error %s: expected %0h, got %0h", name, exp, act);
			errors++;
		end
	endtask

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic bit is_mapped(input logic [7:0] code);
		case (code)
			8'h16, 8'h1e, 8'h2e, 8'h36, 8'h46, 8'h4d, 8'h11, 8'h6b, 8'h74, 8'h29: return 1;
			default: return 0;
		endcase
	endfunction

	// Up walks 00,01,11,10 and down walks 00,10,11,01
	function automatic logic [1:0] next_quad(input logic [1:0] cur, input logic up);
		case (cur)
			2'b00:   return up ? 2'b01 : 2'b10;
			2'b01:   return up ? 2'b11 : 2'b00;
			2'b11:   return up ? 2'b10 : 2'b01;
			default: return up ? 2'b00 : 2'b11;
		endcase
	endfunction

	task automatic send_key(input logic [7:0] code, input logic pressed);
		key_tog = ~key_tog;
		ps2_key = {key_tog, pressed, 1'b0, code};
		@(negedge CLK_48M);
	endtask

	task automatic send_mouse(input int mag, input logic neg);
		logic [7:0] dxb;
		dxb       = neg ? 8'(-mag) : 8'(mag);
		mouse_tog = ~mouse_tog;
		ps2_mouse = {mouse_tog, 8'h00, dxb, 3'b000, neg, 2'b00, mouse_btn};
	endtask

	// Counts single steps until |dx| are seen, then watches for stray motion
	task automatic run_mouse(input string name, input int mag, input logic neg);
		logic [1:0] prev;
		int         steps;
		int         cyc;
		prev  = spinner;
		steps = 0;
		cyc   = 0;
		send_mouse(mag, neg);
		while (steps < mag && cyc < (mag + 2) * STEP_CYC) begin
			@(negedge CLK_48M);
			cyc++;
			if (spinner != prev) begin
				check(name, next_quad(prev, neg), spinner);
				prev = spinner;
				steps++;
			end
		end
		if (steps < mag) begin
			$display("%s: spinner stopped after %0d of %0d steps", name, steps, mag);
			errors++;
		end
		repeat (2 * STEP_CYC) begin
			@(negedge CLK_48M);
			if (spinner != prev) begin
				$display("%s: spinner kept moving after the report was drained", name);
				errors++;
				prev = spinner;
			end
		end
		emu_pat = prev;
	endtask

	task automatic run_enc(input string name, input int n, input logic [31:0] shot_exp);
		logic [1:0] io_pat;
		logic [1:0] want;
		int         cyc;
		io_pat        = 2'b11;
		io_spinner_en = 1'b1;
		@(negedge CLK_48M);
		for (int i = 0; i < n; i++) begin
			user_in[0] = ~user_in[0];
			user_in[1] = ~user_in[0];  // Keep A xor B set for the up direction
			want = next_quad(io_pat, 1'b1);
			cyc  = 0;
			// At least one edge so the emulator pattern cannot stand in
			do begin
				@(negedge CLK_48M);
				cyc++;
			end while (spinner != want && cyc < 16);
			check(name, want, spinner);
			io_pat = want;
		end
		user_in[3] = 1'b0;  // Cabinet fire pressed
		@(negedge CLK_48M);
		check(name, shot_exp, game_in);
		// Mouse report hands the spinner back to the emulator
		send_mouse(1, 1'b0);
		repeat (16) @(negedge CLK_48M);
		want = next_quad(emu_pat, 1'b0);
		cyc  = 0;
		while (spinner != want && cyc < 2 * STEP_CYC) begin
			@(negedge CLK_48M);
			cyc++;
		end
		check(name, want, spinner);
		check(name, 32'h3f, game_in);  // Fire on user_in ignored now
		emu_pat    = want;
		user_in[3] = 1'b1;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		int          fd;
		int          n;
		int          err_before;
		int          failed;
		string       line;
		string       nm;
		string       kd;
		logic [31:0] va;
		logic [31:0] vb;
		logic [31:0] vc;
		logic [31:0] ve;
		logic [31:0] rnd;
		rst_n         = 1'b0;
		ps2_key       = '0;
		ps2_mouse     = '0;
		joy           = '0;
		user_in       = 8'hff;
		io_spinner_en = 1'b0;
		dl            = '0;
		failed        = 0;
		fd = $fopen("test/controls_trace.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the trace file test/controls_trace.txt");
			$display("** FAIL **");
			$finish;
		end else begin
			while (!$feof(fd)) begin
				if ($fgets(line, fd) > 0 && line.getc(0) != "#") begin
					n = $sscanf(line, "%s %s %h %h %h %h", nm, kd, va, vb, vc, ve);
					if (n == 6) begin
						t_name.push_back(nm);
						t_kind.push_back(kd);
						t_a.push_back(va);
						t_b.push_back(vb);
						t_c.push_back(vc);
						t_exp.push_back(ve);
						// Step count per row with random magnitudes capped at 8
						if (kd == "mouse")
							budget += (va == 0) ? 8 : int'(va);
						else if (kd == "enc")
							budget += int'(va) + 1;
					end
				end
			end
			$fclose(fd);
			budget = (budget + 4 * t_name.size()) * STEP_CYC + 10000;
			loaded = 1;
			repeat (2) @(posedge CLK_48M);
			@(negedge CLK_48M);
			rst_n = 1'b1;
			@(negedge CLK_48M);
			foreach (t_name[i]) begin
				err_before = errors;
				case (t_kind[i])
					"rst": begin
						check(t_name[i], t_a[i], game_in);
						check(t_name[i], t_b[i], spinner);
						check(t_name[i], t_c[i], dip_sw);
					end
					"key": begin
						send_key(t_a[i][7:0], t_b[i][0]);
						check(t_name[i], t_exp[i], game_in);
						do rnd = take_bits(8); while (is_mapped(rnd[7:0]));
						send_key(rnd[7:0], 1'b1);  // Unknown code filler
						check(t_name[i], t_exp[i], game_in);
					end
					"joy": begin
						joy = t_a[i];
						mouse_btn = t_b[i][1:0];
						ps2_mouse[1:0] = mouse_btn;
						@(negedge CLK_48M);
						check(t_name[i], t_exp[i], game_in);
					end
					"dip": begin
						dl = {1'b1, t_a[i][7:0], t_b[i][24:0], t_c[i][7:0]};
						@(negedge CLK_48M);
						dl.wr = 1'b0;
						@(negedge CLK_48M);
						check(t_name[i], t_exp[i], dip_sw);
					end
					"mouse": begin
						rnd = take_bits(3);
						run_mouse(t_name[i], (t_a[i] == 0) ? int'(rnd) + 1 : int'(t_a[i]),
						          t_b[i][0]);
					end
					"enc": run_enc(t_name[i], int'(t_a[i]), t_exp[i]);
					default: begin
						$display("%s: unknown row kind %s in the trace", t_name[i], t_kind[i]);
						errors++;
					end
				endcase
				if (errors != err_before)
					failed++;
				$display("%s: %s", t_name[i], (errors == err_before) ? "ok" : "FAILED");
			end
			$display("%0d tests, %0d passed, %0d failed", t_name.size(),
			         t_name.size() - failed, failed);
			if (errors == 0)
				$display("** PASS **");
			else
				$display("** FAIL **");
			$finish;
		end
	end

	// Watchdog sized from the trace step counts
	initial begin
		wait (loaded);
		repeat (budget) @(posedge CLK_48M);
		$display("Timeout: the tests did not finish in the expected time");
		$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire
